//--- issueStamp.sv
// Issue stamper
// Accepts tokens from issue when the pipe is not stalled and tags each
// accepted token with a wrapping issue number

`timescale 1ns/1ps
`default_nettype none

module issueStamp
	import maPkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     stall,
	input  wire maInput_t inToken,
	output maToken_t      stampedToken,
	output issueNo_t      nextIssue
);

	issueNo_t issueCnt;
	logic     accept;

	assign accept = inToken.valid & ~stall;

	// Counter advances once per accepted token
	always_ff @(posedge clock) begin
		if (reset) begin
			issueCnt <= '0;
		end else if (accept) begin
			issueCnt <= issueCnt + 1'b1;
		end
	end

	always_comb begin
		stampedToken.valid   = accept;    // Refused tokens never reach the pipe
		stampedToken.opClass = inToken.opClass;
		stampedToken.chain   = inToken.chain;
		stampedToken.issueNo = issueCnt;
		stampedToken.data    = inToken.data;
	end

	assign nextIssue = issueCnt;

endmodule

`default_nettype wire

//--- maPkg.sv
// Multiply-add token pipe, shared types
// Token layouts as they arrive from issue and as they travel through
// the multiply and add queues, plus the op class and issue number

`default_nettype none

package maPkg;

	// Issue number, wraps around
	typedef logic [7:0] issueNo_t;

	// Op class of a token
	typedef enum logic {
		opAdd = 1'b0,
		opMlt = 1'b1
	} opClass_t;

	//////////////////////////////////////////////////////////////////////////
	// Token from issue, 19 bits
	typedef struct packed {
		logic        valid;
		opClass_t    opClass;
		logic        chain;    // On a multiply, continue into add
		logic [15:0] data;     // Opaque tag
	} maInput_t;

	//////////////////////////////////////////////////////////////////////////
	// Stamped token, 27 bits
	typedef struct packed {
		logic        valid;
		opClass_t    opClass;
		logic        chain;
		issueNo_t    issueNo;  // Age reference for commit
		logic [15:0] data;
	} maToken_t;

endpackage

`default_nettype wire

//--- maUnit.f
maPkg.sv
ringBuffCtrl.sv
issueStamp.sv
tokenPipeMa.sv
maUnit.sv
tbClock.sv
maUnit_chk.sv
maUnit_tb.sv

//--- maUnit.sv
// Multiply-add unit top level
// Issue stamper in front of the multiply-add token pipe; the commit
// side drives grant and hold and takes tokens from outToken

`timescale 1ns/1ps
`default_nettype none

module maUnit
	import maPkg::*;
#(
	parameter int depthMlt = 7,
	parameter int depthAdd = 5
) (
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     hold,
	input  wire logic     grant,
	input  wire maInput_t inToken,
	output maToken_t      outToken,
	output logic          stall
);

	maToken_t stampedToken;
	issueNo_t nextIssue;

	////////////////////////////////////////////////////////////////////////////
	// Issue side

	issueStamp stamp0 (
		.clock(clock),
		.reset(reset),
		.stall(stall),              // Refuses input while the pipe is busy
		.inToken(inToken),
		.stampedToken(stampedToken),
		.nextIssue(nextIssue)
	);

	////////////////////////////////////////////////////////////////////////////
	// Queues and commit side

	tokenPipeMa #(
		.depthMlt(depthMlt),
		.depthAdd(depthAdd)
	) pipe0 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.grant(grant),
		.inToken(stampedToken),
		.nextIssue(nextIssue),      // Age reference
		.outToken(outToken),
		.stall(stall)
	);

endmodule

`default_nettype wire

//--- maUnit_chk.sv
// Token pipe checker
// Concurrent assertions on the output token, stall and chain transfer

`timescale 1ns/1ps
`default_nettype none

module maUnit_chk
	import maPkg::*;
(
	input wire logic     clock,
	input wire logic     reset,
	input wire maToken_t outToken,
	input wire logic     stall,
	input wire logic     fullMlt,
	input wire logic     fullAdd,
	input wire logic     emptyMlt,
	input wire logic     emptyAdd,
	input wire logic     chainMove,
	input wire logic     inValid
);

	// Nothing shown from two empty queues
	assert property (@(posedge clock) disable iff (reset) (emptyMlt && emptyAdd) |-> !outToken.valid)
		else $error("outToken valid while both queues are empty");

	assert property (@(posedge clock) disable iff (reset) (fullMlt || fullAdd) |-> stall)
		else $error("stall low with a full queue");

	assert property (@(posedge clock) disable iff (reset) chainMove |-> !inValid)
		else $error("chain transfer and input write in the same cycle");

endmodule

bind tokenPipeMa maUnit_chk chk0 (
	.clock(clock),
	.reset(reset),
	.outToken(outToken),
	.stall(stall),
	.fullMlt(fullMlt),
	.fullAdd(fullAdd),
	.emptyMlt(emptyMlt),
	.emptyAdd(emptyAdd),
	.chainMove(chainMove),
	.inValid(inToken.valid)
);

`default_nettype wire

//--- maUnit_tb.sv
// Testbench for the multiply-add unit
// Directed tests checked against a queue model of issue numbering,
// chain transfer and age-ordered retirement

`timescale 1ns/1ps
`default_nettype none

module maUnit_tb
	import maPkg::*;
();

	localparam int depthMlt = 7;
	localparam int depthAdd = 5;
	localparam int testCycles = 100;    // Reset plus all tests, rounded up

	logic     clock;
	logic     reset;
	logic     hold;
	logic     grant;
	maInput_t inToken;
	maToken_t outToken;
	logic     stall;

	// Reference model state
	maToken_t mltQ[$];
	maToken_t addQ[$];
	issueNo_t modelIssue;
	logic     accepted;
	logic     retired;
	maToken_t retiredTok;

	// What the DUT did in the same cycle
	logic     dutTaken;
	logic     dutRetired;

	integer seed;
	int errors;
	int testsRun;
	int testsBad;

	tbClock clk0 (.clock(clock), .reset(reset));

	maUnit #(
		.depthMlt(depthMlt),
		.depthAdd(depthAdd)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.grant(grant),
		.inToken(inToken),
		.outToken(outToken),
		.stall(stall)
	);

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// Older eligible head, add head wins a tie
	task automatic modelHead(output maToken_t tok, output logic fromMlt);
		logic     mltOk;
		logic     addOk;
		issueNo_t ageMlt;
		issueNo_t ageAdd;
		mltOk = mltQ.size() > 0 && !mltQ[0].chain;
		addOk = addQ.size() > 0;
		ageMlt = mltOk ? modelIssue - mltQ[0].issueNo : '0;
		ageAdd = addOk ? modelIssue - addQ[0].issueNo : '0;
		fromMlt = mltOk && (!addOk || ageMlt > ageAdd);
		tok = fromMlt ? mltQ[0] : (addOk ? addQ[0] : '0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One clock cycle: check outputs mid-cycle, then step the model

	task automatic tick();
		maToken_t expTok;
		maToken_t moved;
		logic     fromMlt;
		logic     chainMove;
		logic     expStall;
		@(negedge clock);
		modelHead(expTok, fromMlt);
		chainMove = mltQ.size() > 0 && mltQ[0].chain && addQ.size() < depthAdd;
		expStall = mltQ.size() == depthMlt || addQ.size() == depthAdd || chainMove;
		compare("outToken", 32'(expTok), 32'(outToken));
		compare("stall", 32'(expStall), 32'(stall));
		accepted = inToken.valid && !expStall;
		retired = grant && !hold && expTok.valid;
		retiredTok = outToken;
		dutTaken = inToken.valid && !stall;
		dutRetired = grant && !hold && outToken.valid;
		@(posedge clock);
		if (retired && fromMlt) mltQ.delete(0);
		if (retired && !fromMlt) addQ.delete(0);
		if (chainMove) begin
			moved = mltQ.pop_front();
			moved.opClass = opAdd;
			moved.chain = 1'b0;
			addQ.push_back(moved);
		end
		if (accepted) begin
			moved.valid = 1'b1;
			moved.opClass = inToken.opClass;
			moved.chain = inToken.chain && inToken.opClass == opMlt;
			moved.issueNo = modelIssue;
			moved.data = inToken.data;
			if (inToken.opClass == opMlt) mltQ.push_back(moved);
			else addQ.push_back(moved);
			modelIssue++;
		end
		#10;
	endtask

	// Present a token until it is accepted
	task automatic issueToken(input opClass_t cls, input logic chain, input logic [15:0] data);
		int tries;
		tries = 0;
		inToken = {1'b1, cls, chain, data};
		do begin
			tick();
			tries++;
		end while (!accepted && tries < 40);
		if (!accepted) begin
			$display("Token with data %h was never accepted", data);
			errors++;
		end
		inToken.valid = 1'b0;
	endtask

	// Retire count tokens, expecting consecutive issue numbers
	task automatic drain(input int count, input issueNo_t firstNo);
		int       seen;
		int       tries;
		issueNo_t expNo;
		seen = 0;
		tries = 0;
		grant = 1'b1;
		while (seen < count && tries < 4 * count + 10) begin
			tick();
			tries++;
			if (dutRetired) begin
				expNo = firstNo + seen[7:0];
				compare("retired issueNo", 32'(expNo), 32'(retiredTok.issueNo));
				seen++;
			end
		end
		grant = 1'b0;
		compare("retired count", count, seen);
	endtask

	task automatic endTest(input string name, input int errBefore);
		testsRun++;
		if (errors == errBefore) begin
			$display("Test %s: ok", name);
		end else begin
			testsBad++;
			$display("Test %s: %0d errors", name, errors - errBefore);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic testReset();
		int errBefore;
		errBefore = errors;
		tick();
		compare("outToken.valid", 0, 32'(outToken.valid));
		compare("stall", 0, 32'(stall));
		endTest("reset state", errBefore);
	endtask

	task automatic testSingleAdd();
		int          errBefore;
		logic [15:0] data;
		errBefore = errors;
		data = 16'($random(seed));
		issueToken(opAdd, 1'b0, data);
		compare("outToken.valid", 1, 32'(outToken.valid));    // Shown one cycle later
		compare("outToken.data", 32'(data), 32'(outToken.data));
		compare("outToken.issueNo", 0, 32'(outToken.issueNo));
		compare("outToken.chain", 0, 32'(outToken.chain));
		drain(1, 8'd0);
		compare("outToken.valid", 0, 32'(outToken.valid));
		endTest("single add", errBefore);
	endtask

	task automatic testIssueOrder();
		int       errBefore;
		issueNo_t firstNo;
		errBefore = errors;
		firstNo = modelIssue;
		for (int i = 0; i < 6; i++) begin
			issueToken((i % 3 == 1) ? opAdd : opMlt, 1'b0, 16'($random(seed)));
		end
		drain(6, firstNo);
		endTest("issue order", errBefore);
	endtask

	task automatic testChain();
		int          errBefore;
		int          tries;
		issueNo_t    firstNo;
		logic [15:0] data;
		errBefore = errors;
		firstNo = modelIssue;
		data = 16'($random(seed));
		tries = 0;
		issueToken(opMlt, 1'b1, data);
		while (!outToken.valid && tries < 10) begin
			tick();
			tries++;
		end
		compare("outToken.opClass", 32'(opAdd), 32'(outToken.opClass));
		compare("outToken.chain", 0, 32'(outToken.chain));
		compare("outToken.data", 32'(data), 32'(outToken.data));
		compare("outToken.issueNo", 32'(firstNo), 32'(outToken.issueNo));
		drain(1, firstNo);
		endTest("chain transfer", errBefore);
	endtask

	task automatic testBackPressure();
		int       errBefore;
		int       count;
		issueNo_t firstNo;
		errBefore = errors;
		firstNo = modelIssue;
		count = 0;
		for (int i = 0; i < depthMlt + 3; i++) begin
			inToken = {1'b1, opMlt, 1'b0, 16'($random(seed))};
			tick();
			if (!dutTaken) break;
			count++;
		end
		inToken.valid = 1'b0;
		compare("accepted count", depthMlt, count);
		compare("stall", 1, 32'(stall));
		drain(depthMlt, firstNo);
		compare("stall", 0, 32'(stall));
		endTest("back-pressure", errBefore);
	endtask

	task automatic testHold();
		int       errBefore;
		issueNo_t firstNo;
		maToken_t shown;
		logic     fromMlt;
		errBefore = errors;
		firstNo = modelIssue;
		issueToken(opAdd, 1'b0, 16'($random(seed)));
		issueToken(opMlt, 1'b0, 16'($random(seed)));
		modelHead(shown, fromMlt);
		hold = 1'b1;
		grant = 1'b1;
		repeat (5) begin
			tick();
			compare("outToken", 32'(shown), 32'(outToken));    // Frozen under hold
		end
		hold = 1'b0;
		drain(2, firstNo);
		endTest("hold", errBefore);
	endtask

	initial begin
		seed = 32'hd7ca;
		errors = 0;
		testsRun = 0;
		testsBad = 0;
		hold = 1'b0;
		grant = 1'b0;
		inToken = '0;
		modelIssue = '0;
		@(negedge reset);
		testReset();
		testSingleAdd();
		testIssueOrder();
		testChain();
		testBackPressure();
		testHold();
		$display("%0d tests run, %0d failed, %0d check errors", testsRun, testsBad, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog, twice the expected run length
	initial begin
		#(testCycles * 100 * 2);
		$display("Timeout after %0d cycles, the tests did not finish", testCycles * 2);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- ringBuffCtrl.sv
// Ring buffer controller
// Write and read pointers that wrap at numEntry, with an occupancy
// count driving full and empty

`timescale 1ns/1ps
`default_nettype none

module ringBuffCtrl #(
	parameter int numEntry = 4
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        we,
	input  wire logic                        re,
	output logic [$clog2(numEntry)-1:0]      wAddr,
	output logic [$clog2(numEntry)-1:0]      rAddr,
	output logic                             full,
	output logic                             empty,
	output logic [$clog2(numEntry):0]        num
);

	localparam int addrW = $clog2(numEntry);
	localparam logic [addrW-1:0] lastAddr = addrW'(numEntry - 1);
	localparam logic [addrW:0] maxNum = (addrW + 1)'(numEntry);

	// Pointers
	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr <= '0;
			rAddr <= '0;
		end else begin
			if (we) begin
				wAddr <= (wAddr == lastAddr) ? '0 : wAddr + 1'b1;
			end
			if (re) begin
				rAddr <= (rAddr == lastAddr) ? '0 : rAddr + 1'b1;
			end
		end
	end

	// Occupancy, unchanged on simultaneous write and read
	always_ff @(posedge clock) begin
		if (reset) begin
			num <= '0;
		end else if (we && !re) begin
			num <= num + 1'b1;
		end else if (re && !we) begin
			num <= num - 1'b1;
		end
	end

	assign full  = (num == maxNum);
	assign empty = (num == '0);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the maUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module maUnit_tb -f maUnit.f -o simMaUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simMaUnit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

//--- tbClock.sv
// Testbench clock and reset
// 100 ns clock, reset held high for the first resetCycles cycles

`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int resetCycles = 10
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#10 reset = 1'b0;    // Released 10 ns after the edge like other inputs
	end

endmodule

`default_nettype wire

//--- tokenPipeMa.sv
// Multiply-add token pipe
// Multiply and add token queues, chain transfer from the multiply head
// to the add tail, and retirement of the older eligible head

`timescale 1ns/1ps
`default_nettype none

module tokenPipeMa
	import maPkg::*;
#(
	parameter int depthMlt = 7,
	parameter int depthAdd = 5
) (
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     hold,
	input  wire logic     grant,
	input  wire maToken_t inToken,
	input  wire issueNo_t nextIssue,
	output maToken_t      outToken,
	output logic          stall
);

	localparam int widthMlt = $clog2(depthMlt);
	localparam int widthAdd = $clog2(depthAdd);

	// Queue storage
	maToken_t buffMlt [depthMlt];
	maToken_t buffAdd [depthAdd];

	logic [widthMlt-1:0] wAddrMlt;
	logic [widthMlt-1:0] rAddrMlt;
	logic                fullMlt;
	logic                emptyMlt;
	logic [widthAdd-1:0] wAddrAdd;
	logic [widthAdd-1:0] rAddrAdd;
	logic                fullAdd;
	logic                emptyAdd;

	maToken_t mltHead;
	maToken_t addHead;
	maToken_t chainToken;
	maToken_t addWrite;
	logic     mltHeadValid;
	logic     addHeadValid;
	logic     chainMove;
	logic     mltElig;
	logic     addElig;
	issueNo_t ageMlt;
	issueNo_t ageAdd;
	logic     selMlt;
	logic     retire;
	logic     weMlt;
	logic     weAdd;
	logic     reMlt;
	logic     reAdd;

	////////////////////////////////////////////////////////////////////////////
	// Heads and chain transfer

	assign mltHead      = buffMlt[rAddrMlt];
	assign addHead      = buffAdd[rAddrAdd];
	assign mltHeadValid = ~emptyMlt & mltHead.valid;
	assign addHeadValid = ~emptyAdd & addHead.valid;

	// Chained multiply continues as an add
	assign chainMove = mltHeadValid & mltHead.chain & ~fullAdd;

	always_comb begin
		chainToken         = mltHead;
		chainToken.opClass = opAdd;
		chainToken.chain   = 1'b0;
	end

	// Input and transfer never meet here, stall keeps inputs out
	always_comb begin
		if (chainMove) begin
			addWrite = chainToken;
		end else begin
			addWrite       = inToken;
			addWrite.chain = 1'b0;    // Chain only means something on a multiply
		end
	end

	assign stall = fullMlt | fullAdd | chainMove;

	////////////////////////////////////////////////////////////////////////////
	// Retirement select by issue age

	assign mltElig = mltHeadValid & ~mltHead.chain;
	assign addElig = addHeadValid;

	assign ageMlt = nextIssue - mltHead.issueNo;    // Wrapping difference
	assign ageAdd = nextIssue - addHead.issueNo;

	// Ties go to the add head
	assign selMlt = mltElig & (~addElig | (ageMlt > ageAdd));

	assign outToken = selMlt  ? mltHead :
	                  addElig ? addHead :
	                            '0;

	assign retire = grant & ~hold & (mltElig | addElig);

	assign weMlt = inToken.valid & (inToken.opClass == opMlt);
	assign weAdd = (inToken.valid & (inToken.opClass == opAdd)) | chainMove;
	assign reMlt = (retire & selMlt) | chainMove;
	assign reAdd = retire & ~selMlt;

	////////////////////////////////////////////////////////////////////////////
	// Queue arrays

	always_ff @(posedge clock) begin
		if (weMlt) begin
			buffMlt[wAddrMlt] <= inToken;
		end
		if (reMlt) begin
			buffMlt[rAddrMlt].valid <= 1'b0;    // Head leaves
		end
	end

	always_ff @(posedge clock) begin
		if (weAdd) begin
			buffAdd[wAddrAdd] <= addWrite;
		end
		if (reAdd) begin
			buffAdd[rAddrAdd].valid <= 1'b0;
		end
	end

	ringBuffCtrl #(
		.numEntry(depthMlt)
	) ringMlt (
		.clock(clock),
		.reset(reset),
		.we(weMlt),
		.re(reMlt),
		.wAddr(wAddrMlt),
		.rAddr(rAddrMlt),
		.full(fullMlt),
		.empty(emptyMlt),
		.num()
	);

	ringBuffCtrl #(
		.numEntry(depthAdd)
	) ringAdd (
		.clock(clock),
		.reset(reset),
		.we(weAdd),
		.re(reAdd),
		.wAddr(wAddrAdd),
		.rAddr(rAddrAdd),
		.full(fullAdd),
		.empty(emptyAdd),
		.num()
	);

endmodule

`default_nettype wire
